/* source/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// instruction RAM, 256 words
`define IMEM_AW 8

// data RAM, 256 words
`define DMEM_AW 8

`define RESET_PC 32'h0000_0000 // first fetch address

`define RA_REG 5'd31 // JAL link register

`endif

/* source/isa_pkg.sv */
package isa_pkg;

   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [15:0] imm16_t;
   typedef logic [25:0] jtarget_t;

   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00, // R-type, see funct
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_e;

   typedef enum logic [5:0] {
      F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA = 6'h03, F_JR  = 6'h08,
      F_ADDU = 6'h21, F_SUBU = 6'h23, F_AND = 6'h24, F_OR  = 6'h25,
      F_XOR  = 6'h26, F_SLT  = 6'h2a, F_SLTU = 6'h2b
   } funct_e;

endpackage

/* source/core_pkg.sv */
`include "mips_cfg.svh"

package core_pkg;

   typedef logic [31:0]          word_t;
   typedef logic [1:0]           byte_off_t;
   typedef logic [`IMEM_AW-1:0]  imem_addr_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
      ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   typedef enum logic {A_REG, A_SHAMT} a_sel_e; // shifts take shamt

   typedef enum logic [1:0] {B_REG, B_SEXT, B_ZEXT} b_sel_e;

   typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_LINK} dest_sel_e;

   typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;

   typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;

endpackage

/* source/ex_mw_if.sv */
`timescale 1ns/1ps

interface ex_mw_if;
   import isa_pkg::*;
   import core_pkg::*;

   logic      valid;
   word_t     alu_result;  // also the data address
   word_t     store_data;  // already in its lane
   logic [3:0] byte_en;    // bit 3 is bits 31..24
   logic      mem_read;
   logic      mem_write;
   mem_size_e mem_size;
   logic      load_signed;
   wb_sel_e   wb_sel;
   logic      reg_write;
   reg_addr_t dest;

   modport ex (output valid, alu_result, store_data, byte_en, mem_read, mem_write,
               mem_size, load_signed, wb_sel, reg_write, dest);

   modport mw (input valid, alu_result, store_data, byte_en, mem_read, mem_write,
               mem_size, load_signed, wb_sel, reg_write, dest);

endinterface

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
   input  isa_pkg::instr_t      instr,
   output core_pkg::alu_op_e    alu_op,
   output core_pkg::a_sel_e     a_sel,
   output core_pkg::b_sel_e     b_sel,
   output core_pkg::dest_sel_e  dest_sel,
   output core_pkg::wb_sel_e    wb_sel,
   output logic                 mem_read,
   output logic                 mem_write,
   output core_pkg::mem_size_e  mem_size,
   output logic                 load_signed,
   output logic                 reg_write,
   output logic                 is_branch,
   output logic                 branch_ne,
   output logic                 is_jump,
   output logic                 is_jr
);
   import isa_pkg::*;
   import core_pkg::*;

   always_comb begin
      // defaults give a no-op
      alu_op = ALU_ADD;  a_sel = A_REG;  b_sel = B_REG;
      dest_sel = DEST_RT;  wb_sel = WB_ALU;  mem_size = SIZE_WORD;
      {mem_read, mem_write, load_signed, reg_write} = 4'b0000;
      {is_branch, branch_ne, is_jump, is_jr} = 4'b0000;
      case (opcode_e'(instr[31:26]))
         OP_SPECIAL: begin
            dest_sel = DEST_RD;
            reg_write = 1'b1;
            case (funct_e'(instr[5:0]))
               F_ADDU: alu_op = ALU_ADD;
               F_SUBU: alu_op = ALU_SUB;
               F_AND:  alu_op = ALU_AND;
               F_OR:   alu_op = ALU_OR;
               F_XOR:  alu_op = ALU_XOR;
               F_SLT:  alu_op = ALU_SLT;
               F_SLTU: alu_op = ALU_SLTU;
               F_SLL:  begin alu_op = ALU_SLL; a_sel = A_SHAMT; end
               F_SRL:  begin alu_op = ALU_SRL; a_sel = A_SHAMT; end
               F_SRA:  begin alu_op = ALU_SRA; a_sel = A_SHAMT; end
               F_JR:   begin is_jr = 1'b1; reg_write = 1'b0; end
               default: reg_write = 1'b0; // unknown funct
            endcase
         end
         OP_ADDIU: begin b_sel = B_SEXT; reg_write = 1'b1; end
         OP_SLTI:  begin alu_op = ALU_SLT; b_sel = B_SEXT; reg_write = 1'b1; end
         OP_ANDI:  begin alu_op = ALU_AND; b_sel = B_ZEXT; reg_write = 1'b1; end
         OP_ORI:   begin alu_op = ALU_OR;  b_sel = B_ZEXT; reg_write = 1'b1; end
         OP_XORI:  begin alu_op = ALU_XOR; b_sel = B_ZEXT; reg_write = 1'b1; end
         OP_LUI:   begin alu_op = ALU_LUI; b_sel = B_ZEXT; reg_write = 1'b1; end
         OP_BEQ:   is_branch = 1'b1;
         OP_BNE:   begin is_branch = 1'b1; branch_ne = 1'b1; end
         OP_J:     is_jump = 1'b1;
         OP_JAL:   begin is_jump = 1'b1; dest_sel = DEST_LINK; reg_write = 1'b1; end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            b_sel = B_SEXT;  wb_sel = WB_LOAD;
            mem_read = 1'b1;  reg_write = 1'b1;
            load_signed = (instr[31:26] == OP_LB) || (instr[31:26] == OP_LH);
            if (instr[27:26] == 2'b11) mem_size = SIZE_WORD;
            else if (instr[26]) mem_size = SIZE_HALF; // LH, LHU
            else mem_size = SIZE_BYTE;
         end
         OP_SB:    begin b_sel = B_SEXT; mem_write = 1'b1; mem_size = SIZE_BYTE; end
         OP_SH:    begin b_sel = B_SEXT; mem_write = 1'b1; mem_size = SIZE_HALF; end
         OP_SW:    begin b_sel = B_SEXT; mem_write = 1'b1; end
         default: ; // unsupported, stays a no-op
      endcase
   end

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetch_stage (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  logic                 stall,
   input  logic                 imem_we,
   input  core_pkg::imem_addr_t imem_addr,
   input  isa_pkg::instr_t      imem_wdata,
   input  core_pkg::pc_sel_e    pc_sel,
   input  core_pkg::word_t      branch_target,
   input  isa_pkg::jtarget_t    jump_target,
   input  core_pkg::word_t      reg_target,
   output isa_pkg::instr_t      instr,
   output core_pkg::word_t      pc_plus4
);
   import isa_pkg::*;
   import core_pkg::*;

   instr_t imem [0:(2**`IMEM_AW)-1];
   word_t  pc;
   word_t  next_pc;
   instr_t instr_q;
   logic   nop_flag; // first fetch after reset not yet done

   always_comb begin
      case (pc_sel)
         PC_BRANCH: next_pc = branch_target;
         PC_JUMP:   next_pc = {pc[31:28], jump_target, 2'b00}; // pc is the delay slot here
         PC_REG:    next_pc = reg_target;
         default:   next_pc = pc + 32'd4;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= `RESET_PC;
         nop_flag <= 1'b1;
      end else if (!stall) begin
         pc       <= next_pc;
         nop_flag <= 1'b0;
      end
   end

   // loader port, active even under stall
   always_ff @(posedge CLK) begin
      if (imem_we) imem[imem_addr] <= imem_wdata;
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         instr_q  <= imem[pc[`IMEM_AW+1:2]];
         pc_plus4 <= pc + 32'd4;
      end
   end

   assign instr = nop_flag ? instr_t'(0) : instr_q; // RAM output is stale right after reset

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module execute_stage (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               stall,
   input  isa_pkg::instr_t    instr,
   input  core_pkg::word_t    pc_plus4,
   input  logic               wb_we,
   input  isa_pkg::reg_addr_t wb_dest,
   input  core_pkg::word_t    wb_data,
   ex_mw_if.ex                exo,
   output core_pkg::pc_sel_e  pc_sel,
   output core_pkg::word_t    branch_target,
   output isa_pkg::jtarget_t  jump_target,
   output core_pkg::word_t    reg_target
);
   import isa_pkg::*;
   import core_pkg::*;

   reg_addr_t rs, rt, rd, dest;
   imm16_t    imm;
   word_t     regs [1:31]; // r0 is not stored
   word_t     rs_val, rt_val, op_a, op_b, alu_out, ex_result, store_data;
   byte_off_t off;
   logic [3:0] byte_en;
   logic      take;
   alu_op_e   alu_op;
   a_sel_e    a_sel;
   b_sel_e    b_sel;
   dest_sel_e dest_sel;
   wb_sel_e   wb_sel;
   mem_size_e mem_size;
   logic      mem_read, mem_write, load_signed, reg_write;
   logic      is_branch, branch_ne, is_jump, is_jr;

   instr_decoder u_dec (
      .instr(instr), .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel),
      .dest_sel(dest_sel), .wb_sel(wb_sel), .mem_read(mem_read),
      .mem_write(mem_write), .mem_size(mem_size), .load_signed(load_signed),
      .reg_write(reg_write), .is_branch(is_branch), .branch_ne(branch_ne),
      .is_jump(is_jump), .is_jr(is_jr)
   );

   assign rs  = instr[25:21];
   assign rt  = instr[20:16];
   assign rd  = instr[15:11];
   assign imm = instr[15:0];

   always_ff @(posedge CLK) begin
      if (wb_we) regs[wb_dest] <= wb_data; // wb_we never set for r0
   end

   // forward the writeback result, covers distance 1
   assign rs_val = (rs == '0) ? '0 : (wb_we && wb_dest == rs) ? wb_data : regs[rs];
   assign rt_val = (rt == '0) ? '0 : (wb_we && wb_dest == rt) ? wb_data : regs[rt];

   assign op_a = (a_sel == A_SHAMT) ? {27'b0, instr[10:6]} : rs_val;

   always_comb begin
      case (b_sel)
         B_SEXT:  op_b = {{16{imm[15]}}, imm};
         B_ZEXT:  op_b = {16'h0000, imm};
         default: op_b = rt_val;
      endcase
      case (alu_op)
         ALU_ADD:  alu_out = op_a + op_b;
         ALU_SUB:  alu_out = op_a - op_b;
         ALU_AND:  alu_out = op_a & op_b;
         ALU_OR:   alu_out = op_a | op_b;
         ALU_XOR:  alu_out = op_a ^ op_b;
         ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: alu_out = {31'b0, op_a < op_b};
         ALU_SLL:  alu_out = op_b << op_a[4:0];
         ALU_SRL:  alu_out = op_b >> op_a[4:0];
         ALU_SRA:  alu_out = word_t'($signed(op_b) >>> op_a[4:0]);
         ALU_LUI:  alu_out = {op_b[15:0], 16'h0000};
         default:  alu_out = '0;
      endcase
      case (dest_sel)
         DEST_RD:   dest = rd;
         DEST_LINK: dest = `RA_REG;
         default:   dest = rt;
      endcase
   end

   assign ex_result = (dest_sel == DEST_LINK) ? pc_plus4 + 32'd4 : alu_out; // JAL links PC+8

   assign take          = is_branch && ((rs_val == rt_val) ^ branch_ne);
   assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
   assign jump_target   = instr[25:0];
   assign reg_target    = rs_val;
   assign pc_sel = is_jr ? PC_REG : is_jump ? PC_JUMP : take ? PC_BRANCH : PC_SEQ;

   // big-endian lanes, offset 0 is the top byte
   assign off = alu_out[1:0];
   always_comb begin
      case (mem_size)
         SIZE_BYTE: begin
            store_data = {4{rt_val[7:0]}};
            byte_en    = 4'b1000 >> off;
         end
         SIZE_HALF: begin
            store_data = {2{rt_val[15:0]}};
            byte_en    = off[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            store_data = rt_val;
            byte_en    = 4'b1111;
         end
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         exo.valid     <= 1'b0;
         exo.reg_write <= 1'b0;
         exo.mem_read  <= 1'b0;
         exo.mem_write <= 1'b0;
      end else if (!stall) begin
         exo.valid     <= 1'b1;
         exo.reg_write <= reg_write;
         exo.mem_read  <= mem_read;
         exo.mem_write <= mem_write;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         exo.alu_result  <= ex_result;
         exo.store_data  <= store_data;
         exo.byte_en     <= byte_en;
         exo.mem_size    <= mem_size;
         exo.load_signed <= load_signed;
         exo.wb_sel      <= wb_sel;
         exo.dest        <= dest;
      end
   end

endmodule

/* source/mem_writeback.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mem_writeback (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               stall,
   ex_mw_if.mw                mwi,
   output logic               wb_we,
   output isa_pkg::reg_addr_t wb_dest,
   output core_pkg::word_t    wb_data
);
   import isa_pkg::*;
   import core_pkg::*;

   word_t     dmem [0:(2**`DMEM_AW)-1];
   logic [`DMEM_AW-1:0] waddr;
   logic      dmem_we;
   byte_off_t off;
   word_t     rd_word, load_val;
   logic [7:0]  lane8;
   logic [15:0] lane16;

   assign waddr   = mwi.alu_result[`DMEM_AW+1:2];
   assign off     = mwi.alu_result[1:0];
   assign dmem_we = rst_n && mwi.valid && mwi.mem_write && !stall;

   // enabled lanes written at the end of the MW cycle
   always_ff @(posedge CLK) begin
      if (dmem_we) begin
         for (int i = 0; i < 4; i++) begin
            if (mwi.byte_en[i]) dmem[waddr][i*8 +: 8] <= mwi.store_data[i*8 +: 8];
         end
      end
   end

   assign rd_word = mwi.mem_read ? dmem[waddr] : '0;

   always_comb begin
      case (off)
         2'd0:    lane8 = rd_word[31:24];
         2'd1:    lane8 = rd_word[23:16];
         2'd2:    lane8 = rd_word[15:8];
         default: lane8 = rd_word[7:0];
      endcase
      lane16 = off[1] ? rd_word[15:0] : rd_word[31:16];
      case (mwi.mem_size)
         SIZE_BYTE: load_val = {{24{lane8[7] & mwi.load_signed}}, lane8};
         SIZE_HALF: load_val = {{16{lane16[15] & mwi.load_signed}}, lane16};
         default:   load_val = rd_word;
      endcase
   end

   assign wb_data = (mwi.wb_sel == WB_LOAD) ? load_val : mwi.alu_result;
   assign wb_dest = mwi.dest;
   assign wb_we   = mwi.valid && mwi.reg_write && !stall && (mwi.dest != '0); // r0 never written

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  logic                 stall,
   input  logic                 imem_we,
   input  core_pkg::imem_addr_t imem_addr,
   input  isa_pkg::instr_t      imem_wdata,
   output logic                 wb_valid,
   output isa_pkg::reg_addr_t   wb_reg,
   output core_pkg::word_t      wb_data
);
   import isa_pkg::*;
   import core_pkg::*;

   instr_t   instr;
   word_t    pc_plus4, branch_target, reg_target;
   jtarget_t jump_target;
   pc_sel_e  pc_sel;

   ex_mw_if ex_mw ();

   fetch_stage u_fetch (
      .CLK(CLK), .rst_n(rst_n), .stall(stall), .imem_we(imem_we),
      .imem_addr(imem_addr), .imem_wdata(imem_wdata), .pc_sel(pc_sel),
      .branch_target(branch_target), .jump_target(jump_target),
      .reg_target(reg_target), .instr(instr), .pc_plus4(pc_plus4)
   );

   execute_stage u_exec (
      .CLK(CLK), .rst_n(rst_n), .stall(stall), .instr(instr), .pc_plus4(pc_plus4),
      .wb_we(wb_valid), .wb_dest(wb_reg), .wb_data(wb_data), .exo(ex_mw.ex),
      .pc_sel(pc_sel), .branch_target(branch_target), .jump_target(jump_target),
      .reg_target(reg_target)
   );

   mem_writeback u_mw (
      .CLK(CLK), .rst_n(rst_n), .stall(stall), .mwi(ex_mw.mw),
      .wb_we(wb_valid), .wb_dest(wb_reg), .wb_data(wb_data)
   );

endmodule

/* verif/mips_core_properties.sv */
`timescale 1ns/1ps

module mips_core_properties (
   input logic               CLK,
   input logic               rst_n,
   input logic               stall,
   input logic               wb_valid,
   input isa_pkg::reg_addr_t wb_reg,
   input core_pkg::word_t    wb_data
);
   import isa_pkg::*;

   stall_blocks_wb: assert property (@(posedge CLK) disable iff (!rst_n) stall |-> !wb_valid)
      else $error("writeback seen while stall is high");

   quiet_after_reset: assert property (@(posedge CLK) $rose(rst_n) |=> !wb_valid)
      else $error("writeback in the cycle after reset release");

   no_r0_writeback: assert property (@(posedge CLK) disable iff (!rst_n)
      wb_valid |-> wb_reg != reg_addr_t'(0))
      else $error("writeback to register zero");

   wb_data_known: assert property (@(posedge CLK) disable iff (!rst_n)
      wb_valid |-> !$isunknown(wb_data))
      else $error("unknown bits on wb_data");

endmodule

bind mips_core mips_core_properties u_props (.*);

/* verif/mips_core_tb.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_core_tb;
   import isa_pkg::*;
   import core_pkg::*;

   localparam int N_TESTS  = 7;
   localparam int MAX_PROG = 24;
   localparam int MAX_WB   = 16;

   logic       CLK = 1'b0;
   logic       rst_n;
   logic       stall;
   logic       imem_we;
   imem_addr_t imem_addr;
   instr_t     imem_wdata;
   logic       wb_valid;
   reg_addr_t  wb_reg;
   word_t      wb_data;

   // stimulus table, one row per test
   string     names [N_TESTS];
   instr_t    prog [N_TESTS][MAX_PROG];
   int        prog_len [N_TESTS];
   reg_addr_t exp_reg [N_TESTS][MAX_WB];
   word_t     exp_data [N_TESTS][MAX_WB];
   int        exp_cnt [N_TESTS];
   bit        rand_stall [N_TESTS];

   integer seed = 32'h9c26;
   int     bi;          // row being built
   int     nt = 0;
   int     cur;         // row being run
   int     wb_seen;
   int     test_errs;
   bit     running = 1'b0;
   longint limit_ns = 0;

   mips_core UUT (
      .CLK(CLK), .rst_n(rst_n), .stall(stall), .imem_we(imem_we),
      .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
   );

   always #5 CLK = ~CLK;

   function automatic instr_t rtype(funct_e f, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sh);
      return {OP_SPECIAL, rs, rt, rd, sh, f};
   endfunction

   function automatic instr_t itype(opcode_e op, reg_addr_t rs, reg_addr_t rt, imm16_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic instr_t jtype(opcode_e op, jtarget_t t);
      return {op, t};
   endfunction

   task automatic new_test(string n, bit rs);
      bi = nt;
      names[bi] = n;
      rand_stall[bi] = rs;
      prog_len[bi] = 0;
      exp_cnt[bi] = 0;
      nt++;
   endtask

   task automatic emit(instr_t w);
      prog[bi][prog_len[bi]] = w;
      prog_len[bi]++;
   endtask

   task automatic expect_wb(reg_addr_t r, word_t d);
      exp_reg[bi][exp_cnt[bi]] = r;
      exp_data[bi][exp_cnt[bi]] = d;
      exp_cnt[bi]++;
   endtask

   task automatic close_program;
      emit(jtype(OP_J, jtarget_t'(prog_len[bi]))); // spin here
      emit(32'h0000_0000);
   endtask

   task automatic alu_program;
      emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'h1234));  expect_wb(5'd1, 32'h0000_1234);
      emit(itype(OP_LUI, 5'd0, 5'd2, 16'hf000));    expect_wb(5'd2, 32'hf000_0000);
      emit(itype(OP_ORI, 5'd2, 5'd2, 16'h00f0));    expect_wb(5'd2, 32'hf000_00f0);
      emit(rtype(F_ADDU, 5'd1, 5'd2, 5'd4, 5'd0));  expect_wb(5'd4, 32'hf000_1324);
      emit(rtype(F_SUBU, 5'd1, 5'd2, 5'd5, 5'd0));  expect_wb(5'd5, 32'h1000_1144);
      emit(rtype(F_AND, 5'd1, 5'd2, 5'd6, 5'd0));   expect_wb(5'd6, 32'h0000_0030);
      emit(rtype(F_OR, 5'd1, 5'd2, 5'd7, 5'd0));    expect_wb(5'd7, 32'hf000_12f4);
      emit(rtype(F_XOR, 5'd1, 5'd2, 5'd8, 5'd0));   expect_wb(5'd8, 32'hf000_12c4);
      emit(rtype(F_SLL, 5'd0, 5'd1, 5'd9, 5'd4));   expect_wb(5'd9, 32'h0001_2340);
      emit(rtype(F_SRL, 5'd0, 5'd2, 5'd10, 5'd8));  expect_wb(5'd10, 32'h00f0_0000);
      emit(rtype(F_SRA, 5'd0, 5'd2, 5'd11, 5'd8));  expect_wb(5'd11, 32'hfff0_0000);
      emit(itype(OP_ANDI, 5'd7, 5'd12, 16'hff0f));  expect_wb(5'd12, 32'h0000_1204);
      emit(itype(OP_XORI, 5'd1, 5'd13, 16'h00ff));  expect_wb(5'd13, 32'h0000_12cb);
      emit(rtype(F_SLT, 5'd2, 5'd1, 5'd14, 5'd0));  expect_wb(5'd14, 32'd1); // signed
      emit(rtype(F_SLTU, 5'd2, 5'd1, 5'd15, 5'd0)); expect_wb(5'd15, 32'd0);
      close_program();
   endtask

   task automatic build_table;
      new_test("alu", 1'b0);
      alu_program();
      new_test("forward", 1'b0);
      emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'd5));     expect_wb(5'd1, 32'd5);
      emit(rtype(F_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));  expect_wb(5'd2, 32'd10);
      emit(rtype(F_ADDU, 5'd2, 5'd1, 5'd3, 5'd0));  expect_wb(5'd3, 32'd15);
      emit(itype(OP_SW, 5'd0, 5'd3, 16'h0040));
      emit(itype(OP_LW, 5'd0, 5'd4, 16'h0040));     expect_wb(5'd4, 32'd15);
      emit(rtype(F_ADDU, 5'd4, 5'd3, 5'd5, 5'd0));  expect_wb(5'd5, 32'd30); // load-use
      emit(rtype(F_SUBU, 5'd5, 5'd4, 5'd6, 5'd0));  expect_wb(5'd6, 32'd15);
      close_program();
      new_test("load_ext", 1'b0);
      emit(itype(OP_LUI, 5'd0, 5'd1, 16'h852a));    expect_wb(5'd1, 32'h852a_0000);
      emit(itype(OP_ORI, 5'd1, 5'd1, 16'hf061));    expect_wb(5'd1, 32'h852a_f061);
      emit(itype(OP_SW, 5'd0, 5'd1, 16'd16));
      emit(itype(OP_LB, 5'd0, 5'd2, 16'd16));       expect_wb(5'd2, 32'hffff_ff85);
      emit(itype(OP_LB, 5'd0, 5'd3, 16'd17));       expect_wb(5'd3, 32'h0000_002a);
      emit(itype(OP_LB, 5'd0, 5'd4, 16'd18));       expect_wb(5'd4, 32'hffff_fff0);
      emit(itype(OP_LB, 5'd0, 5'd5, 16'd19));       expect_wb(5'd5, 32'h0000_0061);
      emit(itype(OP_LBU, 5'd0, 5'd6, 16'd16));      expect_wb(5'd6, 32'h0000_0085);
      emit(itype(OP_LBU, 5'd0, 5'd7, 16'd17));      expect_wb(5'd7, 32'h0000_002a);
      emit(itype(OP_LBU, 5'd0, 5'd8, 16'd18));      expect_wb(5'd8, 32'h0000_00f0);
      emit(itype(OP_LBU, 5'd0, 5'd9, 16'd19));      expect_wb(5'd9, 32'h0000_0061);
      emit(itype(OP_LH, 5'd0, 5'd10, 16'd16));      expect_wb(5'd10, 32'hffff_852a);
      emit(itype(OP_LH, 5'd0, 5'd11, 16'd18));      expect_wb(5'd11, 32'hffff_f061);
      emit(itype(OP_LHU, 5'd0, 5'd12, 16'd16));     expect_wb(5'd12, 32'h0000_852a);
      emit(itype(OP_LHU, 5'd0, 5'd13, 16'd18));     expect_wb(5'd13, 32'h0000_f061);
      close_program();
      new_test("store_lanes", 1'b0);
      emit(itype(OP_LUI, 5'd0, 5'd1, 16'h1122));    expect_wb(5'd1, 32'h1122_0000);
      emit(itype(OP_ORI, 5'd1, 5'd1, 16'h3344));    expect_wb(5'd1, 32'h1122_3344);
      emit(itype(OP_SW, 5'd0, 5'd1, 16'd32));
      emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'h00ab));  expect_wb(5'd2, 32'h0000_00ab);
      emit(itype(OP_SB, 5'd0, 5'd2, 16'd33));
      emit(itype(OP_LW, 5'd0, 5'd3, 16'd32));       expect_wb(5'd3, 32'h11ab_3344);
      emit(itype(OP_ORI, 5'd0, 5'd4, 16'hcdef));    expect_wb(5'd4, 32'h0000_cdef);
      emit(itype(OP_SH, 5'd0, 5'd4, 16'd34));
      emit(itype(OP_LW, 5'd0, 5'd5, 16'd32));       expect_wb(5'd5, 32'h11ab_cdef);
      emit(itype(OP_SB, 5'd0, 5'd2, 16'd35));
      emit(itype(OP_LW, 5'd0, 5'd6, 16'd32));       expect_wb(5'd6, 32'h11ab_cdab);
      emit(itype(OP_SH, 5'd0, 5'd4, 16'd32));
      emit(itype(OP_LW, 5'd0, 5'd7, 16'd32));       expect_wb(5'd7, 32'hcdef_cdab);
      close_program();
      new_test("branch_jump", 1'b0);
      emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'd7));     expect_wb(5'd1, 32'd7);
      emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'd7));     expect_wb(5'd2, 32'd7);
      emit(itype(OP_BEQ, 5'd1, 5'd2, 16'd2));       // taken, to word 5
      emit(itype(OP_ADDIU, 5'd0, 5'd3, 16'd1));     expect_wb(5'd3, 32'd1);
      emit(itype(OP_ADDIU, 5'd0, 5'd4, 16'h0044));  // skipped
      emit(itype(OP_BNE, 5'd1, 5'd2, 16'd3));       // not taken
      emit(itype(OP_ADDIU, 5'd0, 5'd5, 16'd2));     expect_wb(5'd5, 32'd2);
      emit(itype(OP_BEQ, 5'd1, 5'd0, 16'd3));       // not taken
      emit(itype(OP_ADDIU, 5'd0, 5'd6, 16'd3));     expect_wb(5'd6, 32'd3);
      emit(itype(OP_BNE, 5'd1, 5'd0, 16'd2));       // taken, to word 12
      emit(itype(OP_ADDIU, 5'd0, 5'd7, 16'd4));     expect_wb(5'd7, 32'd4);
      emit(itype(OP_ADDIU, 5'd0, 5'd8, 16'h0088));  // skipped
      emit(jtype(OP_JAL, 26'd16));                  expect_wb(`RA_REG, 32'h0000_0038);
      emit(itype(OP_ADDIU, 5'd0, 5'd9, 16'd5));     expect_wb(5'd9, 32'd5);
      emit(jtype(OP_J, 26'd19));                    // return point of JR
      emit(itype(OP_ADDIU, 5'd0, 5'd10, 16'd6));
      emit(rtype(F_JR, `RA_REG, 5'd0, 5'd0, 5'd0));
      emit(itype(OP_ADDIU, 5'd0, 5'd11, 16'd8));    expect_wb(5'd11, 32'd8);
      expect_wb(5'd10, 32'd6);                      // delay slot of J, runs after JR
      emit(itype(OP_ADDIU, 5'd0, 5'd12, 16'h00cc)); // skipped
      close_program();
      new_test("stall", 1'b1);
      alu_program();
      new_test("reg_zero", 1'b0);
      emit(itype(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
      emit(rtype(F_ADDU, 5'd0, 5'd0, 5'd1, 5'd0));  expect_wb(5'd1, 32'd0);
      emit(itype(OP_ORI, 5'd1, 5'd0, 16'h0077));
      emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'd9));     expect_wb(5'd2, 32'd9);
      emit(itype(OP_LUI, 5'd0, 5'd0, 16'h1234));
      emit(rtype(F_SUBU, 5'd0, 5'd2, 5'd3, 5'd0));  expect_wb(5'd3, 32'hffff_fff7);
      close_program();
   endtask

   task automatic check_reg(reg_addr_t expv, reg_addr_t act);
      if (act !== expv) begin
         $display("Fail %s wb %0d reg: expected r%0d, actual r%0d",
                  names[cur], wb_seen, expv, act);
         test_errs++;
      end
   endtask

   task automatic check_word(word_t expv, word_t act);
      if (act !== expv) begin
         $display("Fail %s wb %0d data: expected %h, actual %h",
                  names[cur], wb_seen, expv, act);
         test_errs++;
      end
   endtask

   // sample one ns before the rising edge, after the falling-edge drive
   always begin
      @(negedge CLK);
      #4;
      if (running && wb_valid) begin
         if (stall) begin
            $display("%s: a writeback appeared while stall was high", names[cur]);
            test_errs++;
         end
         if (wb_seen < exp_cnt[cur]) begin
            check_reg(exp_reg[cur][wb_seen], wb_reg);
            check_word(exp_data[cur][wb_seen], wb_data);
         end else begin
            $display("%s: unexpected extra writeback to r%0d", names[cur], wb_reg);
            test_errs++;
         end
         wb_seen++;
      end
   end

   task automatic load_program(int t);
      for (int i = 0; i < prog_len[t]; i++) begin
         imem_we    = 1'b1;
         imem_addr  = imem_addr_t'(i);
         imem_wdata = prog[t][i];
         @(negedge CLK);
      end
      imem_we = 1'b0;
   endtask

   task automatic run_test(int t);
      int cyc;
      cur = t;
      test_errs = 0;
      wb_seen = 0;
      @(negedge CLK);
      rst_n = 1'b0;
      stall = 1'b1;
      repeat (8) @(negedge CLK);
      rst_n = 1'b1;
      load_program(t);
      running = 1'b1;
      cyc = 0;
      while (wb_seen < exp_cnt[t] && cyc < 2 * prog_len[t] + 16) begin
         stall = rand_stall[t] ? (($random(seed) & 3) == 0) : 1'b0;
         @(negedge CLK);
         cyc++;
      end
      stall = 1'b0;
      repeat (6) @(negedge CLK); // pipeline drain, catches late extras
      running = 1'b0;
      if (wb_seen < exp_cnt[t]) begin
         $display("%s: only %0d of %0d writebacks arrived", names[t], wb_seen, exp_cnt[t]);
         test_errs++;
      end
   endtask

   initial begin
      int     pass_cnt;
      int     fail_cnt;
      longint total;
      pass_cnt = 0;
      fail_cnt = 0;
      total = 0;
      rst_n = 1'b0;
      stall = 1'b1;
      imem_we = 1'b0;
      imem_addr = '0;
      imem_wdata = '0;
      build_table();
      for (int t = 0; t < nt; t++) total += prog_len[t];
      limit_ns = (total + 40) * 4 * 10;
      for (int t = 0; t < nt; t++) begin
         run_test(t);
         if (test_errs == 0) begin
            pass_cnt++;
            $display("%s: pass", names[t]);
         end else begin
            fail_cnt++;
            $display("%s: fail, %0d errors", names[t], test_errs);
         end
      end
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog sized from the table
   initial begin
      wait (limit_ns > 0);
      #(limit_ns);
      $display("watchdog: the run did not finish within %0d ns", limit_ns);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* tb.f */
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/ex_mw_if.sv
source/instr_decoder.sv
source/fetch_stage.sv
source/execute_stage.sv
source/mem_writeback.sv
source/mips_core.sv
verif/mips_core_properties.sv
verif/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mips_core_tb -f tb.f -o mips_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mips_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0
